// ==== hdl/fp_format_pkg.sv ====
package fp_format_pkg;

  // binary64 field widths
  localparam int EXP_W    = 11;
  localparam int FRAC_W   = 52;
  localparam int GRS_BITS = 3;

  // carry, hidden, fraction, then guard/round/sticky
  localparam int SIG_W    = 2 + FRAC_W + GRS_BITS;

  // alignment distance, saturated at 63
  localparam int SHIFT_W  = 6;

  typedef logic [63:0]         fp_word_t;
  typedef logic [EXP_W-1:0]    fp_exp_t;
  typedef logic [FRAC_W-1:0]   fp_frac_t;
  typedef logic [SIG_W-1:0]    fp_sig_t;
  typedef logic [SHIFT_W-1:0]  fp_shift_t;

  // exponent of inf and nan
  localparam fp_exp_t EXP_MAX_BIASED = 11'd2047;

  // every nan result, positive and quiet
  localparam fp_word_t QNAN_DEFAULT = {
    1'b0,
    EXP_MAX_BIASED,
    1'b1,
    {(FRAC_W - 1){1'b0}}
  };

endpackage

// ==== hdl/fadd_ctrl_pkg.sv ====
package fadd_ctrl_pkg;

  // op[2] marks a logic op, op[1:0] then picks which one
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_RSUB = 3'd2,
    OP_AND  = 3'd4,
    OP_OR   = 3'd5,
    OP_XOR  = 3'd6,
    OP_ANDN = 3'd7
  } fadd_op_t;

  typedef enum logic [1:0] {
    RND_TRUNC = 2'd0,
    RND_EVEN  = 2'd1,
    RND_PLUS  = 2'd2,
    RND_MINUS = 2'd3
  } rmode_t;

  typedef logic [3:0] fadd_raise_t;

  // raise vector bit positions
  localparam int RAISE_INV     = 0;
  localparam int RAISE_OVER    = 1;
  localparam int RAISE_UNDER   = 2;
  localparam int RAISE_INEXACT = 3;

endpackage

// ==== hdl/fadd_stage_if.sv ====
`timescale 1ns/10ps

interface fadd_stage_if;
  import fp_format_pkg::*;
  import fadd_ctrl_pkg::*;

  logic        valid;
  logic        is_special;
  fp_word_t    special_res;
  fadd_raise_t special_raise;
  logic        sign_res;
  logic        eff_sub;
  fp_exp_t     exp_big;
  fp_sig_t     sig_big;
  // sticky already folded into bit 0
  fp_sig_t     sig_small_aligned;
  rmode_t      rmode;

  modport align (
    output valid, is_special, special_res, special_raise, sign_res,
    output eff_sub, exp_big, sig_big, sig_small_aligned, rmode
  );

  modport round (
    input valid, is_special, special_res, special_raise, sign_res,
    input eff_sub, exp_big, sig_big, sig_small_aligned, rmode
  );

endinterface

// ==== hdl/fadd_special.sv ====
`timescale 1ns/10ps

module fadd_special (
  input  fp_format_pkg::fp_word_t      a,
  input  fp_format_pkg::fp_word_t      b,
  input  fadd_ctrl_pkg::fadd_op_t      op,
  input  fadd_ctrl_pkg::rmode_t        rmode,
  output logic                         is_special,
  output fp_format_pkg::fp_word_t      special_res,
  output fadd_ctrl_pkg::fadd_raise_t   special_raise
);
  import fp_format_pkg::*;
  import fadd_ctrl_pkg::*;

  fp_exp_t  exp_a;
  fp_exp_t  exp_b;
  fp_frac_t frac_a;
  fp_frac_t frac_b;
  logic     sign_a;
  logic     sign_b;
  logic     zero_a;
  logic     zero_b;
  logic     inf_a;
  logic     inf_b;
  logic     nan_a;
  logic     nan_b;
  logic     snan_any;
  logic     zero_sign;

  assign exp_a  = a[FRAC_W +: EXP_W];
  assign exp_b  = b[FRAC_W +: EXP_W];
  assign frac_a = a[FRAC_W-1:0];
  assign frac_b = b[FRAC_W-1:0];

  // effective signs after sub / rsub
  assign sign_a = a[63] ^ (op == OP_RSUB);
  assign sign_b = b[63] ^ (op == OP_SUB);

  // denormals count as zero here
  assign zero_a = exp_a == '0;
  assign zero_b = exp_b == '0;
  assign inf_a  = exp_a == EXP_MAX_BIASED && frac_a == '0;
  assign inf_b  = exp_b == EXP_MAX_BIASED && frac_b == '0;
  assign nan_a  = exp_a == EXP_MAX_BIASED && frac_a != '0;
  assign nan_b  = exp_b == EXP_MAX_BIASED && frac_b != '0;
  assign snan_any = (nan_a && !frac_a[FRAC_W-1]) || (nan_b && !frac_b[FRAC_W-1]);

  // +0 for opposite signs unless rounding toward minus
  assign zero_sign = (sign_a == sign_b) ? sign_a : (rmode == RND_MINUS);

  always_comb begin
    is_special    = 1'b1;
    special_res   = '0;
    special_raise = '0;
    if (op[2]) begin
      case (op)
        OP_AND:  special_res = a & b;
        OP_OR:   special_res = a | b;
        OP_XOR:  special_res = a ^ b;
        default: special_res = a & ~b;
      endcase
    end else if (nan_a || nan_b) begin
      special_res              = QNAN_DEFAULT;
      special_raise[RAISE_INV] = snan_any;
    end else if (inf_a && inf_b && sign_a != sign_b) begin
      special_res              = QNAN_DEFAULT;
      special_raise[RAISE_INV] = 1'b1;
    end else if (inf_a) begin
      special_res = {sign_a, a[62:0]};
    end else if (inf_b) begin
      special_res = {sign_b, b[62:0]};
    end else if (zero_a && zero_b) begin
      special_res = {zero_sign, 63'b0};
    end else if (zero_a) begin
      special_res = {sign_b, b[62:0]};
    end else if (zero_b) begin
      special_res = {sign_a, a[62:0]};
    end else begin
      is_special = 1'b0;
    end
  end

endmodule

// ==== hdl/fadd_renor.sv ====
`timescale 1ns/10ps

module fadd_renor (
  input  fp_format_pkg::fp_sig_t  sig_in,
  input  fp_format_pkg::fp_exp_t  exp_in,
  output fp_format_pkg::fp_sig_t  sig_out,
  output fp_format_pkg::fp_exp_t  exp_out,
  output logic                    zero,
  output logic                    tiny
);
  import fp_format_pkg::*;

  logic [6:0] byte_has;
  logic [2:0] byte_sel;
  logic [2:0] bit_sel;
  logic [2:0] lead_bytes;
  logic [2:0] lead_bits;
  logic [7:0] top_byte;
  fp_sig_t    sig_med;
  fp_shift_t  shift;

  // bits 55:0 as seven bytes, carry bit is clear after a subtraction
  for (genvar k = 0; k < 7; k++) begin : g_byte
    assign byte_has[k] = |sig_in[8*k +: 8];
  end

  always_comb begin
    byte_sel = '0;
    for (int k = 0; k < 7; k++) begin
      if (byte_has[k]) begin
        byte_sel = 3'(k);
      end
    end
  end

  // first level moves the top byte up to bits 55:48
  assign lead_bytes = 3'd6 - byte_sel;
  assign sig_med    = sig_in << {lead_bytes, 3'b000};
  assign top_byte   = sig_med[SIG_W-2 -: 8];

  always_comb begin
    bit_sel = '0;
    for (int k = 0; k < 8; k++) begin
      if (top_byte[k]) begin
        bit_sel = 3'(k);
      end
    end
  end

  assign lead_bits = 3'd7 - bit_sel;
  assign sig_out   = sig_med << lead_bits;
  assign shift     = {lead_bytes, 3'b000} + fp_shift_t'(lead_bits);
  assign exp_out   = exp_in - shift;

  assign zero = ~|sig_in;
  // exponent would drop below 1
  assign tiny = ~zero && (exp_in <= fp_exp_t'(shift));

endmodule

// ==== hdl/fadd_align.sv ====
`timescale 1ns/10ps

module fadd_align (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  fp_format_pkg::fp_word_t   a,
  input  fp_format_pkg::fp_word_t   b,
  input  fadd_ctrl_pkg::fadd_op_t   op,
  input  fadd_ctrl_pkg::rmode_t     rmode,
  fadd_stage_if.align               stage
);
  import fp_format_pkg::*;
  import fadd_ctrl_pkg::*;

  logic        sign_a;
  logic        sign_b;
  logic        a_more;
  fp_exp_t     exp_big;
  fp_exp_t     exp_small;
  fp_exp_t     exp_diff;
  fp_shift_t   shamt;
  fp_sig_t     sig_big;
  fp_sig_t     sig_small;
  fp_sig_t     sig_shifted;
  fp_sig_t     lost_mask;
  logic        sticky;
  fp_sig_t     sig_aligned;
  logic        is_special;
  fp_word_t    special_res;
  fadd_raise_t special_raise;

  fadd_special u_special (
    .a             (a),
    .b             (b),
    .op            (op),
    .rmode         (rmode),
    .is_special    (is_special),
    .special_res   (special_res),
    .special_raise (special_raise)
  );

  assign sign_a = a[63] ^ (op == OP_RSUB);
  assign sign_b = b[63] ^ (op == OP_SUB);

  // exponent and fraction compare as one unsigned field
  assign a_more = a[EXP_W+FRAC_W-1:0] >= b[EXP_W+FRAC_W-1:0];

  assign exp_big   = a_more ? a[FRAC_W +: EXP_W] : b[FRAC_W +: EXP_W];
  assign exp_small = a_more ? b[FRAC_W +: EXP_W] : a[FRAC_W +: EXP_W];
  assign exp_diff  = exp_big - exp_small;
  assign shamt     = (|exp_diff[EXP_W-1:SHIFT_W]) ? '1 : exp_diff[SHIFT_W-1:0];

  assign sig_big   = {2'b01, a_more ? a[FRAC_W-1:0] : b[FRAC_W-1:0], {GRS_BITS{1'b0}}};
  assign sig_small = {2'b01, a_more ? b[FRAC_W-1:0] : a[FRAC_W-1:0], {GRS_BITS{1'b0}}};

  // bits pushed out below bit 0 collapse into sticky
  assign sig_shifted = sig_small >> shamt;
  assign lost_mask   = ~({SIG_W{1'b1}} << shamt);
  assign sticky      = |(sig_small & lost_mask);
  assign sig_aligned = {sig_shifted[SIG_W-1:1], sig_shifted[0] | sticky};

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      stage.is_special        <= is_special;
      stage.special_res       <= special_res;
      stage.special_raise     <= special_raise;
      stage.sign_res          <= a_more ? sign_a : sign_b;
      stage.eff_sub           <= sign_a ^ sign_b;
      stage.exp_big           <= exp_big;
      stage.sig_big           <= sig_big;
      stage.sig_small_aligned <= sig_aligned;
      stage.rmode             <= rmode;
    end
  end

endmodule

// ==== hdl/fadd_round.sv ====
`timescale 1ns/10ps

module fadd_round (
  input  logic                        clk,
  input  logic                        rst,
  fadd_stage_if.round                 stage,
  output fp_format_pkg::fp_word_t     res,
  output fadd_ctrl_pkg::fadd_raise_t  raise,
  output logic                        valid
);
  import fp_format_pkg::*;
  import fadd_ctrl_pkg::*;

  fp_sig_t          sum;
  fp_sig_t          add_norm;
  logic [EXP_W:0]   add_exp;
  fp_sig_t          sub_norm;
  fp_exp_t          sub_exp;
  logic             sub_zero;
  logic             sub_tiny;
  fp_sig_t          norm;
  logic [EXP_W:0]   exp_norm;
  logic             sign;
  logic             lsb;
  logic             guard;
  logic             rnd_bit;
  logic             inexact;
  logic             round_up;
  logic [FRAC_W+1:0] mant_rnd;
  fp_frac_t         frac_rnd;
  logic [EXP_W:0]   exp_rnd;
  logic             overflow;
  logic             ovf_to_max;
  fp_word_t         res_next;
  fadd_raise_t      raise_next;

  assign sum = stage.eff_sub ? stage.sig_big - stage.sig_small_aligned
                             : stage.sig_big + stage.sig_small_aligned;

  // carry out of an addition shifts right and keeps sticky
  assign add_norm = sum[SIG_W-1] ? {1'b0, sum[SIG_W-1:2], sum[1] | sum[0]} : sum;
  assign add_exp  = {1'b0, stage.exp_big} + sum[SIG_W-1];

  fadd_renor u_renor (
    .sig_in  (sum),
    .exp_in  (stage.exp_big),
    .sig_out (sub_norm),
    .exp_out (sub_exp),
    .zero    (sub_zero),
    .tiny    (sub_tiny)
  );

  assign norm     = stage.eff_sub ? sub_norm : add_norm;
  assign exp_norm = stage.eff_sub ? {1'b0, sub_exp} : add_exp;
  assign sign     = stage.sign_res;

  assign lsb     = norm[GRS_BITS];
  assign guard   = norm[GRS_BITS-1];
  assign rnd_bit = |norm[GRS_BITS-2:0];
  assign inexact = |norm[GRS_BITS-1:0];

  always_comb begin
    case (stage.rmode)
      RND_EVEN:  round_up = guard & (rnd_bit | lsb);
      RND_PLUS:  round_up = ~sign & inexact;
      RND_MINUS: round_up = sign & inexact;
      default:   round_up = 1'b0;
    endcase
  end

  // a rounding carry leaves the fraction at zero and bumps the exponent
  assign mant_rnd = {1'b0, norm[SIG_W-2:GRS_BITS]} + round_up;
  assign frac_rnd = mant_rnd[FRAC_W-1:0];
  assign exp_rnd  = exp_norm + mant_rnd[FRAC_W+1];
  assign overflow = exp_rnd >= {1'b0, EXP_MAX_BIASED};

  // modes that round toward zero for this sign saturate to largest finite
  assign ovf_to_max = (stage.rmode == RND_TRUNC) ||
                      (stage.rmode == RND_PLUS && sign) ||
                      (stage.rmode == RND_MINUS && !sign);

  always_comb begin
    raise_next = '0;
    if (stage.is_special) begin
      res_next   = stage.special_res;
      raise_next = stage.special_raise;
    end else if (stage.eff_sub && sub_zero) begin
      res_next = {stage.rmode == RND_MINUS, 63'b0};
    end else if (stage.eff_sub && sub_tiny) begin
      // flush to signed zero
      res_next                  = {sign, 63'b0};
      raise_next[RAISE_UNDER]   = 1'b1;
      raise_next[RAISE_INEXACT] = 1'b1;
    end else if (overflow) begin
      if (ovf_to_max) begin
        res_next = {sign, EXP_MAX_BIASED - 1'b1, {FRAC_W{1'b1}}};
      end else begin
        res_next = {sign, EXP_MAX_BIASED, {FRAC_W{1'b0}}};
      end
      raise_next[RAISE_OVER]    = 1'b1;
      raise_next[RAISE_INEXACT] = 1'b1;
    end else begin
      res_next                  = {sign, exp_rnd[EXP_W-1:0], frac_rnd};
      raise_next[RAISE_INEXACT] = inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      res   <= '0;
      raise <= '0;
    end else begin
      valid <= stage.valid;
      res   <= stage.valid ? res_next : '0;
      raise <= stage.valid ? raise_next : '0;
    end
  end

endmodule

// ==== hdl/fadd.sv ====
`timescale 1ns/10ps

module fadd (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  fp_format_pkg::fp_word_t     a,
  input  fp_format_pkg::fp_word_t     b,
  input  fadd_ctrl_pkg::fadd_op_t     op,
  input  fadd_ctrl_pkg::rmode_t       rmode,
  output fp_format_pkg::fp_word_t     res,
  output fadd_ctrl_pkg::fadd_raise_t  raise,
  output logic                        valid
);

  // stage 1 to stage 2 registers
  fadd_stage_if stage_bus ();

  fadd_align u_align (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .a     (a),
    .b     (b),
    .op    (op),
    .rmode (rmode),
    .stage (stage_bus.align)
  );

  fadd_round u_round (
    .clk   (clk),
    .rst   (rst),
    .stage (stage_bus.round),
    .res   (res),
    .raise (raise),
    .valid (valid)
  );

endmodule

// ==== tests/fadd_chk.sv ====
`timescale 1ns/10ps

module fadd_chk (
  input logic                       clk,
  input logic                       rst,
  input logic                       en,
  input logic                       valid,
  input fp_format_pkg::fp_word_t    res,
  input fadd_ctrl_pkg::fadd_raise_t raise
);
  import fadd_ctrl_pkg::*;

  // fixed two-cycle latency
  valid_latency: assert property (
    @(posedge clk) disable iff (rst) valid == $past(en, 2)
  ) else $error("valid does not follow en by two cycles");

  idle_outputs_zero: assert property (
    @(posedge clk) disable iff (rst) !valid |-> (res == '0 && raise == '0)
  ) else $error("res or raise nonzero while valid is low");

  reset_clears_valid: assert property (
    @(posedge clk) rst |=> !valid
  ) else $error("valid high during reset");

  // an invalid result is a nan, never an overflow
  inv_excludes_over: assert property (
    @(posedge clk) disable iff (rst) !(raise[RAISE_INV] && raise[RAISE_OVER])
  ) else $error("invalid and overflow raised together");

endmodule

bind fadd fadd_chk u_chk (
  .clk   (clk),
  .rst   (rst),
  .en    (en),
  .valid (valid),
  .res   (res),
  .raise (raise)
);

// ==== tests/fadd_tb.sv ====
`timescale 1ns/10ps

module fadd_tb;
  import fp_format_pkg::*;
  import fadd_ctrl_pkg::*;

  localparam fp_word_t ONE      = 64'h3ff0000000000000;
  localparam fp_word_t ONE_P5   = 64'h3ff8000000000000;
  localparam fp_word_t TWO      = 64'h4000000000000000;
  localparam fp_word_t THREE    = 64'h4008000000000000;
  localparam fp_word_t ULP_HALF = 64'h3ca0000000000000;
  localparam fp_word_t PINF     = 64'h7ff0000000000000;
  localparam fp_word_t DNAN     = 64'h7ff8000000000000;
  localparam fp_word_t MAXF     = 64'h7fefffffffffffff;
  localparam fp_word_t MIN_NORM = 64'h0010000000000000;
  localparam fp_word_t NEG      = 64'h8000000000000000;
  localparam fp_word_t PAT_A    = 64'h0123456789abcdef;
  localparam fp_word_t PAT_B    = 64'hff00ff00ff00ff00;
  localparam int       TIMEOUT  = 20;

  logic        clk = 1'b0;
  logic        rst;
  logic        en;
  fp_word_t    a;
  fp_word_t    b;
  fadd_op_t    op;
  rmode_t      rmode;
  fp_word_t    res;
  fadd_raise_t raise;
  logic        valid;

  // stimulus table with expected values
  fp_word_t    vec_a[$];
  fp_word_t    vec_b[$];
  fadd_op_t    vec_op[$];
  rmode_t      vec_rm[$];
  fp_word_t    vec_res[$];
  fadd_raise_t vec_raise[$];

  // operations in flight
  fp_word_t    exp_res_q[$];
  fadd_raise_t exp_raise_q[$];
  int          exp_cycle_q[$];

  int          errors = 0;
  int          cycle = 0;
  int          seen = 0;
  logic [31:0] lfsr = 32'd64;

  fadd UUT (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .a     (a),
    .b     (b),
    .op    (op),
    .rmode (rmode),
    .res   (res),
    .raise (raise),
    .valid (valid)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // right shifting x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic push_vec(input fp_word_t va, input fp_word_t vb, input fadd_op_t vo,
                          input rmode_t vr, input fp_word_t vres, input fadd_raise_t vflags);
    vec_a.push_back(va);
    vec_b.push_back(vb);
    vec_op.push_back(vo);
    vec_rm.push_back(vr);
    vec_res.push_back(vres);
    vec_raise.push_back(vflags);
  endtask

  task automatic load_table();
    // exact results
    push_vec(ONE, TWO, OP_ADD, RND_EVEN, THREE, 4'h0);
    push_vec(THREE, ONE, OP_SUB, RND_EVEN, TWO, 4'h0);
    push_vec(NEG | ONE, TWO, OP_RSUB, RND_EVEN, THREE, 4'h0);
    push_vec(ONE, 64'h3fe8000000000000, OP_SUB, RND_EVEN, 64'h3fd0000000000000, 4'h0);
    push_vec(ONE, ULP_HALF, OP_SUB, RND_EVEN, 64'h3fefffffffffffff, 4'h0);
    push_vec(ONE_P5, ONE_P5, OP_SUB, RND_EVEN, 64'h0, 4'h0);
    push_vec(ONE_P5, ONE_P5, OP_SUB, RND_MINUS, NEG, 4'h0);
    // ties, then one case per rounding direction
    push_vec(ONE, ULP_HALF, OP_ADD, RND_EVEN, ONE, 4'h8);
    push_vec(ONE | 64'h1, ULP_HALF, OP_ADD, RND_EVEN, ONE | 64'h2, 4'h8);
    push_vec(ONE, 64'h3c90000000000000, OP_SUB, RND_TRUNC, 64'h3fefffffffffffff, 4'h8);
    push_vec(ONE, ULP_HALF, OP_ADD, RND_PLUS, ONE | 64'h1, 4'h8);
    push_vec(NEG | ONE, NEG | ULP_HALF, OP_ADD, RND_MINUS, NEG | ONE | 64'h1, 4'h8);
    push_vec(NEG | ONE, NEG | ULP_HALF, OP_ADD, RND_PLUS, NEG | ONE, 4'h8);
    // special operands
    push_vec(64'h7ff8000000000123, ONE, OP_ADD, RND_EVEN, DNAN, 4'h0);
    push_vec(ONE, 64'h7ff0000000000001, OP_SUB, RND_EVEN, DNAN, 4'h1);
    push_vec(64'h7ff4000000000000, NEG | PINF, OP_ADD, RND_EVEN, DNAN, 4'h1);
    push_vec(PINF, NEG | PINF, OP_ADD, RND_EVEN, DNAN, 4'h1);
    push_vec(PINF, PINF, OP_SUB, RND_EVEN, DNAN, 4'h1);
    push_vec(PINF, ONE, OP_ADD, RND_EVEN, PINF, 4'h0);
    push_vec(ONE, PINF, OP_SUB, RND_EVEN, NEG | PINF, 4'h0);
    push_vec(PINF, ONE, OP_RSUB, RND_EVEN, NEG | PINF, 4'h0);
    push_vec(64'h0, NEG, OP_ADD, RND_EVEN, 64'h0, 4'h0);
    push_vec(64'h0, NEG, OP_ADD, RND_MINUS, NEG, 4'h0);
    push_vec(64'h0, TWO, OP_SUB, RND_EVEN, NEG | TWO, 4'h0);
    // denormal operand reads as zero
    push_vec(64'h1, ONE, OP_ADD, RND_EVEN, ONE, 4'h0);
    // overflow, then flush of tiny results
    push_vec(MAXF, MAXF, OP_ADD, RND_EVEN, PINF, 4'ha);
    push_vec(MAXF, MAXF, OP_ADD, RND_TRUNC, MAXF, 4'ha);
    push_vec(MIN_NORM | 64'h1, MIN_NORM, OP_SUB, RND_EVEN, 64'h0, 4'hc);
    push_vec(NEG | MIN_NORM | 64'h1, NEG | MIN_NORM, OP_SUB, RND_EVEN, NEG, 4'hc);
    // bitwise ops whatever the operands encode
    push_vec(PAT_A, PAT_B, OP_AND, RND_EVEN, 64'h010045008900cd00, 4'h0);
    push_vec(PAT_A, PAT_B, OP_OR, RND_EVEN, 64'hff23ff67ffabffef, 4'h0);
    push_vec(PAT_A, PAT_B, OP_XOR, RND_EVEN, 64'hfe23ba6776ab32ef, 4'h0);
    push_vec(PAT_A, PAT_B, OP_ANDN, RND_EVEN, 64'h0023006700ab00ef, 4'h0);
    push_vec(64'h7ff0000000000001, PINF, OP_XOR, RND_EVEN, 64'h1, 4'h0);
  endtask

  // normal operands with exponents 1008..1039 checked against host arithmetic
  task automatic add_random(input int count);
    logic [63:0] s;
    logic [63:0] e;
    logic [63:0] f;
    logic [63:0] k;
    fp_word_t    x;
    fp_word_t    y;
    fadd_op_t    rop;
    real         ra;
    real         rb;
    real         rs;
    real         bb;
    real         err;
    for (int i = 0; i < count; i++) begin
      take_bits(1, s);
      take_bits(5, e);
      take_bits(52, f);
      x = {s[0], 11'(1008 + e), f[51:0]};
      take_bits(1, s);
      take_bits(5, e);
      take_bits(52, f);
      y = {s[0], 11'(1008 + e), f[51:0]};
      take_bits(2, k);
      rop = (k[1:0] == 2'd1) ? OP_SUB : (k[1:0] == 2'd2) ? OP_RSUB : OP_ADD;
      ra = (rop == OP_RSUB) ? -$bitstoreal(x) : $bitstoreal(x);
      rb = (rop == OP_SUB) ? -$bitstoreal(y) : $bitstoreal(y);
      rs = ra + rb;
      // two-sum error term is nonzero when rounding lost bits
      bb = rs - ra;
      err = (ra - (rs - bb)) + (rb - bb);
      push_vec(x, y, rop, RND_EVEN, $realtobits(rs), (err != 0.0) ? 4'h8 : 4'h0);
    end
  endtask

  task automatic apply_table();
    for (int i = 0; i < vec_a.size(); i++) begin
      @(negedge clk);
      en    = 1'b1;
      a     = vec_a[i];
      b     = vec_b[i];
      op    = vec_op[i];
      rmode = vec_rm[i];
      exp_res_q.push_back(vec_res[i]);
      exp_raise_q.push_back(vec_raise[i]);
      exp_cycle_q.push_back(cycle);
      // an idle slot now and then
      if (i % 8 == 7) begin
        @(negedge clk);
        en = 1'b0;
      end
    end
    @(negedge clk);
    en = 1'b0;
  endtask

  // scoreboard on the falling edge
  always @(negedge clk) begin
    if (cycle > 0) begin
      if (valid === 1'b1) begin
        if (exp_res_q.size() == 0) begin
          errors++;
          $display("Error at %0t: valid went high with no operation in flight", $time);
        end else begin
          check_value("res", res, exp_res_q.pop_front());
          check_value("raise", 64'(raise), 64'(exp_raise_q.pop_front()));
          check_value("latency", 64'(cycle - exp_cycle_q.pop_front()), 64'd2);
          seen++;
        end
      end else begin
        check_value("res", res, 64'd0);
        check_value("raise", 64'(raise), 64'd0);
      end
    end
  end

  initial begin
    int wait_cnt;
    rst   = 1'b1;
    en    = 1'b0;
    a     = '0;
    b     = '0;
    op    = OP_ADD;
    rmode = RND_EVEN;
    load_table();
    add_random(40);
    repeat (2) @(negedge clk);
    rst = 1'b0;
    apply_table();
    wait_cnt = 0;
    while (seen < vec_a.size() && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (seen < vec_a.size()) begin
      errors++;
      $display("Timed out waiting for results, %0d of %0d arrived", seen, vec_a.size());
    end
    // idle tail with valid low
    repeat (3) @(negedge clk);
    @(posedge clk);
    $display("%0d errors in %0d results", errors, seen);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== fadd.f ====
hdl/fp_format_pkg.sv
hdl/fadd_ctrl_pkg.sv
hdl/fadd_stage_if.sv
hdl/fadd_special.sv
hdl/fadd_renor.sv
hdl/fadd_align.sv
hdl/fadd_round.sv
hdl/fadd.sv
tests/fadd_chk.sv
tests/fadd_tb.sv

// ==== Makefile ====
TOP := fadd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f fadd.f --top-module fadd

sim:
	verilator --binary --timing --assert -Wno-fatal -f fadd.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
